/* decode_pkg.sv */
package decode_pkg;
    timeunit 1ns;
    timeprecision 100ps;

    // register form
    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] sa;
        logic [5:0] func;
    } r_fields_t;

    // immediate form, also loads, stores and branches
    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fields_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] jidx;   // word index within the 256MB region
    } j_fields_t;

    typedef union packed {
        r_fields_t r_fields;
        i_fields_t i_fields;
        j_fields_t j_fields;
    } instr_t;

    typedef struct packed {
        instr_t      inst;
        logic [31:0] pc;
    } fetch_bus_t;

    typedef struct packed {
        logic        we;
        logic [4:0]  addr;
        logic [31:0] data;
    } rf_write_t;

    // one later stage as seen from decode
    typedef struct packed {
        logic        valid;
        logic        we;
        logic        is_load;   // value not known until memory returns
        logic [4:0]  addr;
        logic [31:0] value;
    } fwd_bus_t;

    typedef struct packed {
        logic [11:0] alu_op;         // one-hot, see ALU_* below
        logic        src1_is_sa;
        logic        src1_is_pc;
        logic        src2_is_imm;
        logic        src2_is_8;      // link address is pc + 8
        logic        zero_ext_imm;
        logic        load_op;
        logic        mem_we;
        logic        gr_we;
        logic [4:0]  dest;
    } ctrl_t;

    typedef struct packed {
        logic beq;
        logic bne;
        logic j;
        logic jal;
        logic jr;
    } br_ctrl_t;

    typedef struct packed {
        ctrl_t       ctrl;
        logic [15:0] imm;
        logic [31:0] rs_value;
        logic [31:0] rt_value;
        logic [31:0] pc;
    } ds_to_es_t;

    typedef struct packed {
        logic        ready;
        logic        taken;
        logic [31:0] target;
    } br_bus_t;

    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    // bit positions in ctrl_t.alu_op
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    localparam logic [4:0] REG_LINK = 5'd31;

endpackage

/* instr_decoder.sv */
module instr_decoder (
    input  decode_pkg::instr_t   inst,
    output decode_pkg::ctrl_t    ctrl,
    output decode_pkg::br_ctrl_t br_kind
);
    timeunit 1ns;
    timeprecision 100ps;
    import decode_pkg::*;

    logic [11:0] fn_alu;      // alu op picked by the function field
    logic        fn_shift;
    logic        fn_alu_ok;
    logic        fn_jr;
    logic        imm_write;   // writes rt, imm as second source
    logic        known;

    always_comb begin
        fn_alu   = '0;
        fn_shift = 1'b0;
        case (inst.r_fields.func)
            FN_ADDU: fn_alu[ALU_ADD]  = 1'b1;
            FN_SUBU: fn_alu[ALU_SUB]  = 1'b1;
            FN_SLT:  fn_alu[ALU_SLT]  = 1'b1;
            FN_SLTU: fn_alu[ALU_SLTU] = 1'b1;
            FN_AND:  fn_alu[ALU_AND]  = 1'b1;
            FN_OR:   fn_alu[ALU_OR]   = 1'b1;
            FN_XOR:  fn_alu[ALU_XOR]  = 1'b1;
            FN_NOR:  fn_alu[ALU_NOR]  = 1'b1;
            FN_SLL: begin
                fn_alu[ALU_SLL] = 1'b1;
                fn_shift        = 1'b1;
            end
            FN_SRL: begin
                fn_alu[ALU_SRL] = 1'b1;
                fn_shift        = 1'b1;
            end
            FN_SRA: begin
                fn_alu[ALU_SRA] = 1'b1;
                fn_shift        = 1'b1;
            end
            default: fn_alu = '0;
        endcase
    end

    // shifts use sa and need rs zero, the others need sa zero
    assign fn_alu_ok = |fn_alu && (fn_shift ? inst.r_fields.rs == 5'd0
                                            : inst.r_fields.sa == 5'd0);
    assign fn_jr     = inst.r_fields.func == FN_JR && inst.r_fields.rt == 5'd0
                    && inst.r_fields.rd == 5'd0 && inst.r_fields.sa == 5'd0;

    always_comb begin
        ctrl      = '0;
        br_kind   = '0;
        imm_write = 1'b0;
        known     = 1'b1;
        case (inst.i_fields.op)
            OP_SPECIAL: begin
                if (fn_alu_ok) begin
                    ctrl.alu_op     = fn_alu;
                    ctrl.src1_is_sa = fn_shift;
                    ctrl.gr_we      = 1'b1;
                end else if (fn_jr) begin
                    br_kind.jr = 1'b1;
                end else begin
                    known = 1'b0;
                end
            end
            OP_ADDIU: begin
                ctrl.alu_op[ALU_ADD] = 1'b1;
                imm_write            = 1'b1;
            end
            OP_ANDI: begin
                ctrl.alu_op[ALU_AND] = 1'b1;
                ctrl.zero_ext_imm    = 1'b1;
                imm_write            = 1'b1;
            end
            OP_ORI: begin
                ctrl.alu_op[ALU_OR] = 1'b1;
                ctrl.zero_ext_imm   = 1'b1;
                imm_write           = 1'b1;
            end
            OP_XORI: begin
                ctrl.alu_op[ALU_XOR] = 1'b1;
                ctrl.zero_ext_imm    = 1'b1;
                imm_write            = 1'b1;
            end
            OP_LUI: begin
                if (inst.i_fields.rs == 5'd0) begin
                    ctrl.alu_op[ALU_LUI] = 1'b1;
                    imm_write            = 1'b1;
                end else begin
                    known = 1'b0;
                end
            end
            OP_LW: begin
                ctrl.alu_op[ALU_ADD] = 1'b1;   // address calc
                ctrl.load_op         = 1'b1;
                imm_write            = 1'b1;
            end
            OP_SW: begin
                ctrl.alu_op[ALU_ADD] = 1'b1;
                ctrl.src2_is_imm     = 1'b1;
                ctrl.mem_we          = 1'b1;
            end
            OP_BEQ: br_kind.beq = 1'b1;
            OP_BNE: br_kind.bne = 1'b1;
            OP_J:   br_kind.j   = 1'b1;
            OP_JAL: begin
                br_kind.jal          = 1'b1;
                ctrl.alu_op[ALU_ADD] = 1'b1;   // pc + 8 into r31
                ctrl.src1_is_pc      = 1'b1;
                ctrl.src2_is_8       = 1'b1;
                ctrl.gr_we           = 1'b1;
            end
            default: known = 1'b0;
        endcase
        if (imm_write) begin
            ctrl.src2_is_imm = 1'b1;
            ctrl.gr_we       = 1'b1;
        end
        if (known) begin
            ctrl.dest = br_kind.jal ? REG_LINK :
                        imm_write   ? inst.i_fields.rt :
                                      inst.r_fields.rd;
        end
    end

    always_comb begin
        a_alu_onehot: assert ($onehot0(ctrl.alu_op))
            else $error("alu_op has more than one bit set: %b", ctrl.alu_op);
    end

endmodule

/* reg_file.sv */
module reg_file (
    input  logic                  clk,
    input  logic [4:0]            raddr1,
    input  logic [4:0]            raddr2,
    input  decode_pkg::rf_write_t wr,
    output logic [31:0]           rdata1,
    output logic [31:0]           rdata2
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (wr.we && wr.addr != 5'd0) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // r0 is hardwired to zero, entry 0 is never written
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

    a_r0_port1: assert property (@(posedge clk) raddr1 == 5'd0 |-> rdata1 == 32'd0)
        else $error("read port 1 of r0 is nonzero");
    a_r0_port2: assert property (@(posedge clk) raddr2 == 5'd0 |-> rdata2 == 32'd0)
        else $error("read port 2 of r0 is nonzero");

endmodule

/* operand_bypass.sv */
module operand_bypass (
    input  decode_pkg::instr_t   inst,
    input  logic [31:0]          rf_rdata1,
    input  logic [31:0]          rf_rdata2,
    input  decode_pkg::fwd_bus_t es_fwd,
    input  decode_pkg::fwd_bus_t ms_fwd,
    input  decode_pkg::fwd_bus_t ws_fwd,
    output logic [31:0]          rs_value,
    output logic [31:0]          rt_value,
    output logic                 load_use_stall
);
    timeunit 1ns;
    timeprecision 100ps;
    import decode_pkg::*;

    logic [4:0] rs;
    logic [4:0] rt;

    function automatic logic writes(fwd_bus_t f, logic [4:0] a);
        return f.valid && f.we && f.addr == a;
    endfunction

    // nearest stage wins, a load in execute has no value yet
    function automatic logic [31:0] pick(logic [4:0] a, logic [31:0] rf_data,
                                         fwd_bus_t es, fwd_bus_t ms, fwd_bus_t ws);
        if (a == 5'd0) begin
            return 32'd0;
        end
        if (writes(es, a) && !es.is_load) begin
            return es.value;
        end
        if (writes(ms, a)) begin
            return ms.value;
        end
        if (writes(ws, a)) begin
            return ws.value;   // same cycle as the rf write
        end
        return rf_data;
    endfunction

    assign rs = inst.r_fields.rs;
    assign rt = inst.r_fields.rt;

    assign rs_value = pick(rs, rf_rdata1, es_fwd, ms_fwd, ws_fwd);
    assign rt_value = pick(rt, rf_rdata2, es_fwd, ms_fwd, ws_fwd);

    assign load_use_stall = es_fwd.is_load
                         && ((rs != 5'd0 && writes(es_fwd, rs))
                          || (rt != 5'd0 && writes(es_fwd, rt)));

    always_comb begin
        a_stall_src: assert (!load_use_stall || (es_fwd.valid && es_fwd.is_load))
            else $error("load-use stall without a load in execute");
    end

endmodule

/* branch_unit.sv */
module branch_unit (
    input  logic                 ds_valid,
    input  logic [31:0]          pc,
    input  decode_pkg::br_ctrl_t br_kind,
    input  logic [15:0]          imm,
    input  logic [25:0]          jidx,
    input  logic [31:0]          rs_value,
    input  logic [31:0]          rt_value,
    input  logic                 load_use_stall,
    output decode_pkg::br_bus_t  br_bus
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0] slot_pc;     // delay slot address
    logic [31:0] br_offset;
    logic        rs_eq_rt;
    logic        cond_met;
    logic        is_cond;

    assign slot_pc   = pc + 32'd4;
    assign br_offset = {{14{imm[15]}}, imm, 2'b00};
    assign rs_eq_rt  = rs_value == rt_value;
    assign is_cond   = br_kind.beq || br_kind.bne;

    assign cond_met = (br_kind.beq && rs_eq_rt)
                   || (br_kind.bne && !rs_eq_rt)
                   || br_kind.j
                   || br_kind.jal
                   || br_kind.jr;

    assign br_bus.ready  = !load_use_stall;   // fetch must wait for real operands
    assign br_bus.taken  = ds_valid && cond_met;
    assign br_bus.target = is_cond    ? slot_pc + br_offset :
                           br_kind.jr ? rs_value :
                                        {slot_pc[31:28], jidx, 2'b00};

endmodule

/* id_stage.sv */
module id_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   es_allowin,
    output logic                   ds_allowin,
    input  logic                   fs_to_ds_valid,
    input  decode_pkg::fetch_bus_t fs_to_ds_bus,
    input  decode_pkg::fwd_bus_t   es_fwd,
    input  decode_pkg::fwd_bus_t   ms_fwd,
    input  decode_pkg::fwd_bus_t   ws_fwd,
    input  decode_pkg::rf_write_t  ws_to_rf,
    output logic                   ds_to_es_valid,
    output decode_pkg::ds_to_es_t  ds_to_es_bus,
    output decode_pkg::br_bus_t    br_bus
);
    timeunit 1ns;
    timeprecision 100ps;
    import decode_pkg::*;

    logic        ds_valid;
    fetch_bus_t  fs_to_ds_r;   // held instruction and pc
    logic        ds_ready_go;
    ctrl_t       ctrl;
    br_ctrl_t    br_kind;
    logic [31:0] rf_rdata1;
    logic [31:0] rf_rdata2;
    logic [31:0] rs_value;
    logic [31:0] rt_value;
    logic        load_use_stall;

    assign ds_ready_go    = !load_use_stall;
    assign ds_allowin     = !ds_valid || (ds_ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ds_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            fs_to_ds_r <= fs_to_ds_bus;
        end
    end

    instr_decoder u_decoder (
        .inst    (fs_to_ds_r.inst),
        .ctrl    (ctrl),
        .br_kind (br_kind)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .raddr1 (fs_to_ds_r.inst.r_fields.rs),
        .raddr2 (fs_to_ds_r.inst.r_fields.rt),
        .wr     (ws_to_rf),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    operand_bypass u_bypass (
        .inst           (fs_to_ds_r.inst),
        .rf_rdata1      (rf_rdata1),
        .rf_rdata2      (rf_rdata2),
        .es_fwd         (es_fwd),
        .ms_fwd         (ms_fwd),
        .ws_fwd         (ws_fwd),
        .rs_value       (rs_value),
        .rt_value       (rt_value),
        .load_use_stall (load_use_stall)
    );

    branch_unit u_branch (
        .ds_valid       (ds_valid),
        .pc             (fs_to_ds_r.pc),
        .br_kind        (br_kind),
        .imm            (fs_to_ds_r.inst.i_fields.imm),
        .jidx           (fs_to_ds_r.inst.j_fields.jidx),
        .rs_value       (rs_value),
        .rt_value       (rt_value),
        .load_use_stall (load_use_stall),
        .br_bus         (br_bus)
    );

    assign ds_to_es_bus.ctrl     = ctrl;
    assign ds_to_es_bus.imm      = fs_to_ds_r.inst.i_fields.imm;
    assign ds_to_es_bus.rs_value = rs_value;
    assign ds_to_es_bus.rt_value = rt_value;
    assign ds_to_es_bus.pc       = fs_to_ds_r.pc;

    a_valid_out: assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid |-> ds_valid)
        else $error("ds_to_es_valid without ds_valid");

endmodule

/* tb_vectors.svh */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// columns: inst, pc, es_fwd, ms_fwd, ws_fwd, es_allowin, rf write {we, addr, data}
//   then expected: ds_to_es_valid, ds_allowin, ctrl, rs_value, rt_value, taken, target, ready
// ctrl is {alu_op, sa pc imm 8 zext ld mwe gwe, dest}; r8 = 80001230 and r9 = 00000100
localparam int         NUM_ROWS = 18;
localparam logic [31:0] PC0     = 32'hbfc00100;
localparam fwd_bus_t   NO_FWD   = '0;
localparam rf_write_t  NO_WRITE = '0;

row_t vectors [NUM_ROWS] = '{
    // OP_SPECIAL/FN_ADDU r10, r8, r0, r8 written on the same edge
    '{32'h01005021, PC0, NO_FWD, NO_FWD, NO_FWD, 1'b1, {1'b1, 5'd8, 32'h80001230},
      1'b1, 1'b1, {12'h001, 8'b0000_0001, 5'd10}, 32'h80001230, 32'h0, 1'b0, 32'h0, 1'b1},
    // FN_SUBU r11, r9, r8
    '{32'h01285823, PC0, NO_FWD, NO_FWD, NO_FWD, 1'b1, {1'b1, 5'd9, 32'h00000100},
      1'b1, 1'b1, {12'h002, 8'b0000_0001, 5'd11}, 32'h00000100, 32'h80001230, 1'b0, 32'h0, 1'b1},
    // FN_SLL r12, r9, 4
    '{32'h00096100, PC0, NO_FWD, NO_FWD, NO_FWD, 1'b1, NO_WRITE,
      1'b1, 1'b1, {12'h100, 8'b1000_0001, 5'd12}, 32'h0, 32'h00000100, 1'b0, 32'h0, 1'b1},
    // OP_ANDI r9, r8, 0xff00
    '{32'h3109ff00, PC0, NO_FWD, NO_FWD, NO_FWD, 1'b1, NO_WRITE,
      1'b1, 1'b1, {12'h010, 8'b0010_1001, 5'd9}, 32'h80001230, 32'h00000100, 1'b0, 32'h0, 1'b1},
    // OP_LUI r9, 0x1234
    '{32'h3c091234, PC0, NO_FWD, NO_FWD, NO_FWD, 1'b1, NO_WRITE,
      1'b1, 1'b1, {12'h800, 8'b0010_0001, 5'd9}, 32'h0, 32'h00000100, 1'b0, 32'h0, 1'b1},
    // OP_ADDIU r9, r8, -4
    '{32'h2509fffc, PC0, NO_FWD, NO_FWD, NO_FWD, 1'b1, NO_WRITE,
      1'b1, 1'b1, {12'h001, 8'b0010_0001, 5'd9}, 32'h80001230, 32'h00000100, 1'b0, 32'h0, 1'b1},
    // OP_LW r9, 8(r8)
    '{32'h8d090008, PC0, NO_FWD, NO_FWD, NO_FWD, 1'b1, NO_WRITE,
      1'b1, 1'b1, {12'h001, 8'b0010_0101, 5'd9}, 32'h80001230, 32'h00000100, 1'b0, 32'h0, 1'b1},
    // OP_SW r9, 4(r8), dest is the rd field
    '{32'had090004, PC0, NO_FWD, NO_FWD, NO_FWD, 1'b1, NO_WRITE,
      1'b1, 1'b1, {12'h001, 8'b0010_0010, 5'd0}, 32'h80001230, 32'h00000100, 1'b0, 32'h0, 1'b1},
    // addu r10, r8, r9 with execute beating memory on r8
    '{32'h01095021, PC0, {3'b110, 5'd8, 32'haaaa0001}, {3'b110, 5'd8, 32'hbbbb0002},
      {3'b110, 5'd9, 32'hcccc0003}, 1'b1, NO_WRITE,
      1'b1, 1'b1, {12'h001, 8'b0000_0001, 5'd10}, 32'haaaa0001, 32'hcccc0003, 1'b0, 32'h0, 1'b1},
    // memory beats writeback
    '{32'h01095021, PC0, NO_FWD, {3'b110, 5'd8, 32'hbbbb0002}, {3'b110, 5'd8, 32'hcccc0003},
      1'b1, NO_WRITE,
      1'b1, 1'b1, {12'h001, 8'b0000_0001, 5'd10}, 32'hbbbb0002, 32'h00000100, 1'b0, 32'h0, 1'b1},
    // load in execute writes r9, load-use stall
    '{32'h01095021, PC0, {3'b111, 5'd9, 32'hdead0004}, NO_FWD, NO_FWD, 1'b1, NO_WRITE,
      1'b0, 1'b0, {12'h001, 8'b0000_0001, 5'd10}, 32'h80001230, 32'h00000100, 1'b0, 32'h0, 1'b0},
    // execute blocked
    '{32'h01095021, PC0, NO_FWD, NO_FWD, NO_FWD, 1'b0, NO_WRITE,
      1'b1, 1'b0, {12'h001, 8'b0000_0001, 5'd10}, 32'h80001230, 32'h00000100, 1'b0, 32'h0, 1'b1},
    // OP_BEQ r8, r8, +3
    '{32'h11080003, PC0, NO_FWD, NO_FWD, NO_FWD, 1'b1, NO_WRITE,
      1'b1, 1'b1, 25'h0, 32'h80001230, 32'h80001230, 1'b1, 32'hbfc00110, 1'b1},
    // OP_BNE r8, r9, -2, rd field reads 31
    '{32'h1509fffe, PC0, NO_FWD, NO_FWD, NO_FWD, 1'b1, NO_WRITE,
      1'b1, 1'b1, {12'h000, 8'b0000_0000, 5'd31}, 32'h80001230, 32'h00000100, 1'b1,
      32'hbfc000fc, 1'b1},
    // bne r8, r8 falls through
    '{32'h15080008, PC0, NO_FWD, NO_FWD, NO_FWD, 1'b1, NO_WRITE,
      1'b1, 1'b1, 25'h0, 32'h80001230, 32'h80001230, 1'b0, 32'h0, 1'b1},
    // OP_J
    '{32'h08000040, PC0, NO_FWD, NO_FWD, NO_FWD, 1'b1, NO_WRITE,
      1'b1, 1'b1, 25'h0, 32'h0, 32'h0, 1'b1, 32'hb0000100, 1'b1},
    // OP_JAL links to r31
    '{32'h0c008004, PC0, NO_FWD, NO_FWD, NO_FWD, 1'b1, NO_WRITE,
      1'b1, 1'b1, {12'h001, 8'b0101_0001, 5'd31}, 32'h0, 32'h0, 1'b1, 32'hb0020010, 1'b1},
    // FN_JR r8, target forwarded from execute
    '{32'h01000008, PC0, {3'b110, 5'd8, 32'hbfc02000}, NO_FWD, NO_FWD, 1'b1, NO_WRITE,
      1'b1, 1'b1, 25'h0, 32'hbfc02000, 32'h0, 1'b1, 32'hbfc02000, 1'b1}
};

`endif

/* tb_id_stage.sv */
module tb_id_stage;
    timeunit 1ns;
    timeprecision 100ps;
    import decode_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 16;
    localparam int DRIVE_DELAY  = 10;   // after the rising edge

    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] pc;
        fwd_bus_t    es_fwd;
        fwd_bus_t    ms_fwd;
        fwd_bus_t    ws_fwd;
        logic        es_allowin;
        rf_write_t   rf_wr;
        logic        exp_to_es_valid;
        logic        exp_allowin;
        ctrl_t       exp_ctrl;
        logic [31:0] exp_rs;
        logic [31:0] exp_rt;
        logic        exp_taken;
        logic [31:0] exp_target;   // only checked when taken
        logic        exp_ready;
    } row_t;

    `include "tb_vectors.svh"

    logic       clk;
    logic       reset;
    logic       es_allowin;
    logic       ds_allowin;
    logic       fs_to_ds_valid;
    fetch_bus_t fs_to_ds_bus;
    fwd_bus_t   es_fwd;
    fwd_bus_t   ms_fwd;
    fwd_bus_t   ws_fwd;
    rf_write_t  ws_to_rf;
    logic       ds_to_es_valid;
    ds_to_es_t  ds_to_es_bus;
    br_bus_t    br_bus;
    int         row_errors;
    int         tests_failed;

    id_stage DUT (
        .clk            (clk),
        .reset          (reset),
        .es_allowin     (es_allowin),
        .ds_allowin     (ds_allowin),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_to_ds_bus),
        .es_fwd         (es_fwd),
        .ms_fwd         (ms_fwd),
        .ws_fwd         (ws_fwd),
        .ws_to_rf       (ws_to_rf),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus),
        .br_bus         (br_bus)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else begin
            $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
            row_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        if (row_errors == 0) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: failed with %0d error(s)", name, row_errors);
            tests_failed++;
        end
        row_errors = 0;
    endtask

    // returns right after an edge that saw ds_allowin high
    task automatic wait_allowin_edge();
        logic open;
        open = 1'b0;
        while (!open) begin
            @(negedge clk);
            open = ds_allowin;
            @(posedge clk);
        end
    endtask

    task automatic check_row(input row_t v);
        compare("ds_to_es_valid", 32'(ds_to_es_valid), 32'(v.exp_to_es_valid));
        compare("ds_allowin", 32'(ds_allowin), 32'(v.exp_allowin));
        compare("ctrl", 32'(ds_to_es_bus.ctrl), 32'(v.exp_ctrl));
        compare("imm", 32'(ds_to_es_bus.imm), 32'(v.inst[15:0]));
        compare("rs_value", ds_to_es_bus.rs_value, v.exp_rs);
        compare("rt_value", ds_to_es_bus.rt_value, v.exp_rt);
        compare("pc", ds_to_es_bus.pc, v.pc);
        compare("br taken", 32'(br_bus.taken), 32'(v.exp_taken));
        compare("br ready", 32'(br_bus.ready), 32'(v.exp_ready));
        if (v.exp_taken) begin
            compare("br target", br_bus.target, v.exp_target);
        end
    endtask

    task automatic run_row(input int i);
        row_t v;
        v = vectors[i];
        @(posedge clk);
        #DRIVE_DELAY;
        fs_to_ds_valid = 1'b0;   // drain the stage first
        es_allowin     = 1'b1;
        es_fwd         = NO_FWD;
        ms_fwd         = NO_FWD;
        ws_fwd         = NO_FWD;
        ws_to_rf       = NO_WRITE;
        wait_allowin_edge();
        #DRIVE_DELAY;
        fs_to_ds_valid = 1'b1;
        fs_to_ds_bus   = {v.inst, v.pc};
        es_fwd         = v.es_fwd;
        ms_fwd         = v.ms_fwd;
        ws_fwd         = v.ws_fwd;
        es_allowin     = v.es_allowin;
        ws_to_rf       = v.rf_wr;
        wait_allowin_edge();
        #DRIVE_DELAY;
        fs_to_ds_bus = '0;   // nop, would show up if a blocked stage took it
        @(negedge clk);
        check_row(v);
        if (!v.exp_allowin) begin
            @(posedge clk);
            @(negedge clk);
            check_row(v);   // nothing moves while blocked
        end
        finish_test($sformatf("row %0d inst %h", i, v.inst));
    endtask

    initial begin
        #((NUM_ROWS * 4 + RESET_CYCLES) * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", NUM_ROWS * 4 + RESET_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        es_allowin     = 1'b1;
        fs_to_ds_valid = 1'b0;
        fs_to_ds_bus   = '0;
        es_fwd         = NO_FWD;
        ms_fwd         = NO_FWD;
        ws_fwd         = NO_FWD;
        ws_to_rf       = NO_WRITE;
        row_errors     = 0;
        tests_failed   = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        @(negedge clk);
        compare("ds_to_es_valid", 32'(ds_to_es_valid), 32'd0);
        compare("br taken", 32'(br_bus.taken), 32'd0);
        compare("ds_allowin", 32'(ds_allowin), 32'd1);
        finish_test("after reset");
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        $display("tests %0d, passed %0d, failed %0d",
                 NUM_ROWS + 1, NUM_ROWS + 1 - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+.
decode_pkg.sv
instr_decoder.sv
reg_file.sv
operand_bypass.sv
branch_unit.sv
id_stage.sv
tb_id_stage.sv

/* Makefile */
TOOL       = verilator
TOP        = tb_id_stage
FILELIST   = sim.f
SIM_FLAGS  = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only -Wall --timing
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = TESTBENCH PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
